// File: src/lsu_pkg.sv
// shared widths, access types and bus structs of the load-store unit, imported by every LSU file
package lsu_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // data bus width in bits
  localparam int unsigned DataWidth = 32;
  // byte address width
  localparam int unsigned AddrWidth = 32;
  // one enable per byte lane
  localparam int unsigned BeWidth   = DataWidth / 8;

  ////////////////////////////////////////
  // basic types
  ////////////////////////////////////////

  typedef logic [DataWidth-1:0] lsu_word_t;
  typedef logic [AddrWidth-1:0] lsu_addr_t;
  typedef logic [BeWidth-1:0]   lsu_be_t;

  // access size, encoding 2'b11 is never issued
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  ////////////////////////////////////////
  // request and bus payloads
  ////////////////////////////////////////

  // held core request, 68 bits
  typedef struct packed {
    logic      we;
    lsu_type_e dtype;
    logic      sign_ext;
    lsu_addr_t addr;
    lsu_word_t wdata;
  } lsu_req_t;

  // bus request payload, addr is always word aligned, 69 bits
  typedef struct packed {
    lsu_addr_t addr;
    logic      we;
    lsu_be_t   be;
    lsu_word_t wdata;
  } mem_req_t;

  // bus response, err only meaningful together with rvalid
  typedef struct packed {
    logic      rvalid;
    logic      err;
    lsu_word_t rdata;
  } mem_rsp_t;

  // load attributes latched at grant for the response that follows
  typedef struct packed {
    logic [1:0] offset;
    lsu_type_e  dtype;
    logic       sign_ext;
    logic       we;
  } rdata_ctrl_t;

endpackage

// File: src/lsu_req_decode.sv
// combinational request decoder of the LSU, turns the held core request into the bus payload
module lsu_req_decode (
  input  lsu_pkg::lsu_req_t lsu_req_i,
  input  logic              second_part_i,
  output lsu_pkg::mem_req_t mem_req_o,
  output logic              split_o
);

  import lsu_pkg::*;

  // byte offset inside the addressed word
  logic [1:0] offset;
  lsu_addr_t  word_addr;
  lsu_be_t    be;
  lsu_word_t  wdata_rot;

  assign offset    = lsu_req_i.addr[1:0];
  assign word_addr = {lsu_req_i.addr[AddrWidth-1:2], 2'b00};

  ////////////////////////////////////////
  // split detection
  ////////////////////////////////////////

  // word at any nonzero offset or halfword crossing into the next word
  assign split_o = ((lsu_req_i.dtype == LSU_WORD) && (offset != 2'b00)) ||
                   ((lsu_req_i.dtype == LSU_HALF) && (offset == 2'b11));

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////

  always_comb begin
    be = '0;
    unique case (lsu_req_i.dtype)
      LSU_WORD: begin
        if (!second_part_i) begin
          // lanes from the offset up to the top of the word
          be = lsu_be_t'(4'b1111 << offset);
        end else begin
          // remaining low lanes of the next word
          be = ~lsu_be_t'(4'b1111 << offset);
        end
      end
      LSU_HALF: begin
        if (!second_part_i) begin
          // two lanes, truncated to lane 3 at offset 3
          be = lsu_be_t'(4'b0011 << offset);
        end else begin
          // upper byte lands in lane 0
          be = 4'b0001;
        end
      end
      LSU_BYTE: begin
        be = lsu_be_t'(4'b0001 << offset);
      end
      default: begin
        // unused size encoding, nothing enabled
        be = '0;
      end
    endcase
  end

  ////////////////////////////////////////
  // store data rotation
  ////////////////////////////////////////

  // rotate left by offset bytes so byte 0 of the register sits in lane offset
  always_comb begin
    unique case (offset)
      2'b00:   wdata_rot = lsu_req_i.wdata;
      2'b01:   wdata_rot = {lsu_req_i.wdata[23:0], lsu_req_i.wdata[31:24]};
      2'b10:   wdata_rot = {lsu_req_i.wdata[15:0], lsu_req_i.wdata[31:16]};
      default: wdata_rot = {lsu_req_i.wdata[7:0], lsu_req_i.wdata[31:8]};
    endcase
  end

  ////////////////////////////////////////
  // bus payload
  ////////////////////////////////////////

  always_comb begin
    mem_req_o.we    = lsu_req_i.we;
    mem_req_o.be    = be;
    mem_req_o.wdata = wdata_rot;
    // second part goes to the following word
    if (second_part_i) begin
      mem_req_o.addr = word_addr + lsu_addr_t'(BeWidth);
    end else begin
      mem_req_o.addr = word_addr;
    end
  end

endmodule

// File: src/lsu_ctrl_fsm.sv
// transfer sequencer of the LSU, issues one or two bus transfers per request and reports completion
module lsu_ctrl_fsm (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic              split_i,
  input  logic              we_i,
  input  lsu_pkg::lsu_addr_t mem_addr_i,
  input  lsu_pkg::lsu_addr_t req_addr_i,
  input  logic              data_gnt_i,
  input  lsu_pkg::mem_rsp_t data_rsp_i,
  output logic              data_req_o,
  output logic              grant_o,
  output logic              second_part_o,
  output logic              valid_o,
  output logic              load_err_o,
  output logic              store_err_o,
  output logic              busy_o,
  output lsu_pkg::lsu_addr_t addr_last_o
);

  import lsu_pkg::*;

  // first-part states are only used by split accesses
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_FIRST,
    WAIT_RVALID_FIRST,
    WAIT_GNT,
    WAIT_RVALID
  } lsu_state_e;

  lsu_state_e state_q, state_d;
  logic       second_part_q, second_part_d;
  logic       we_q;
  lsu_addr_t  addr_last_q;

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    second_part_d = second_part_q;
    data_req_o    = 1'b0;
    valid_o       = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          // request goes out in the same cycle as the core request
          data_req_o = 1'b1;
          if (data_gnt_i) begin
            second_part_d = split_i;
            state_d       = split_i ? WAIT_RVALID_FIRST : WAIT_RVALID;
          end else begin
            state_d       = split_i ? WAIT_GNT_FIRST : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_FIRST: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          second_part_d = 1'b1;
          state_d       = WAIT_RVALID_FIRST;
        end
      end

      WAIT_RVALID_FIRST: begin
        if (data_rsp_i.rvalid) begin
          if (data_rsp_i.err) begin
            // abort, the second word is never requested
            valid_o       = 1'b1;
            second_part_d = 1'b0;
            state_d       = IDLE;
          end else begin
            // second part may go out with the first rvalid
            data_req_o = 1'b1;
            state_d    = data_gnt_i ? WAIT_RVALID : WAIT_GNT;
          end
        end
      end

      WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          state_d = WAIT_RVALID;
        end
      end

      WAIT_RVALID: begin
        if (data_rsp_i.rvalid) begin
          valid_o       = 1'b1;
          second_part_d = 1'b0;
          state_d       = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign grant_o = data_req_o & data_gnt_i;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      second_part_q <= 1'b0;
      we_q          <= 1'b0;
      addr_last_q   <= '0;
    end else begin
      state_q       <= state_d;
      second_part_q <= second_part_d;
      if (grant_o) begin
        we_q <= we_i;
        // first part keeps the byte address, second part the next word
        addr_last_q <= second_part_q ? mem_addr_i : req_addr_i;
      end
    end
  end

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  assign second_part_o = second_part_q;
  assign addr_last_o   = addr_last_q;

  // error type follows the access that owns the outstanding response
  assign load_err_o  = data_rsp_i.rvalid & data_rsp_i.err & ~we_q;
  assign store_err_o = data_rsp_i.rvalid & data_rsp_i.err & we_q;

  // pending request or response still outstanding
  assign busy_o = (state_q != IDLE) | data_req_o;

endmodule

// File: src/lsu_rdata_align.sv
// load data path of the LSU, gathers bytes of one or two response words and extends the result
module lsu_rdata_align (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              grant_i,
  input  logic              second_part_i,
  input  lsu_pkg::lsu_req_t lsu_req_i,
  input  lsu_pkg::mem_rsp_t data_rsp_i,
  output lsu_pkg::lsu_word_t rdata_o
);

  import lsu_pkg::*;

  rdata_ctrl_t ctrl_q;
  // first-part word of a split load
  lsu_word_t   rdata_q;
  lsu_word_t   gathered;
  logic        split;
  logic [2:0]  lane;

  ////////////////////////////////////////
  // captured state
  ////////////////////////////////////////

  // attributes of the granted access, read when its response returns
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '0;
    end else if (grant_i) begin
      ctrl_q.offset   <= lsu_req_i.addr[1:0];
      ctrl_q.dtype    <= lsu_req_i.dtype;
      ctrl_q.sign_ext <= lsu_req_i.sign_ext;
      ctrl_q.we       <= lsu_req_i.we;
    end
  end

  // also written on the final rvalid, after which the word is no longer read
  always_ff @(posedge clk_i) begin
    if (data_rsp_i.rvalid && second_part_i && !ctrl_q.we) begin
      rdata_q <= data_rsp_i.rdata;
    end
  end

  ////////////////////////////////////////
  // byte gathering
  ////////////////////////////////////////

  // split accesses start in the held word and spill into the new one
  assign split = ((ctrl_q.dtype == LSU_WORD) && (ctrl_q.offset != 2'b00)) ||
                 ((ctrl_q.dtype == LSU_HALF) && (ctrl_q.offset == 2'b11));

  always_comb begin
    gathered = '0;
    lane     = '0;
    for (int i = 0; i < BeWidth; i++) begin
      lane = {1'b0, ctrl_q.offset} + 3'(i);
      if (lane[2] || !split) begin
        gathered[8*i +: 8] = data_rsp_i.rdata[8*lane[1:0] +: 8];
      end else begin
        gathered[8*i +: 8] = rdata_q[8*lane[1:0] +: 8];
      end
    end
  end

  ////////////////////////////////////////
  // extension
  ////////////////////////////////////////

  always_comb begin
    unique case (ctrl_q.dtype)
      LSU_HALF: begin
        rdata_o = {{16{ctrl_q.sign_ext & gathered[15]}}, gathered[15:0]};
      end
      LSU_BYTE: begin
        rdata_o = {{24{ctrl_q.sign_ext & gathered[7]}}, gathered[7:0]};
      end
      default: begin
        rdata_o = gathered;
      end
    endcase
  end

endmodule

// File: src/lsu_top.sv
// load-store unit top level, connects request decoder, transfer sequencer and load aligner
module lsu_top (
  input  logic               clk_i,
  input  logic               rst_ni,

  // core side
  input  logic               req_i,
  input  lsu_pkg::lsu_req_t  lsu_req_i,
  output logic               valid_o,
  output lsu_pkg::lsu_word_t rdata_o,
  output logic               load_err_o,
  output logic               store_err_o,
  output logic               busy_o,
  output lsu_pkg::lsu_addr_t addr_last_o,

  // data bus side
  output logic               data_req_o,
  output lsu_pkg::mem_req_t  data_o,
  input  logic               data_gnt_i,
  input  lsu_pkg::mem_rsp_t  data_i
);

  // access needs two transfers
  logic split;
  // high from the cycle after the first grant of a split access
  logic second_part;
  // request and grant in the same cycle
  logic grant;

  ////////////////////////////////////////
  // request decode
  ////////////////////////////////////////

  lsu_req_decode u_req_decode (
    .lsu_req_i     (lsu_req_i),
    .second_part_i (second_part),
    .mem_req_o     (data_o),
    .split_o       (split)
  );

  ////////////////////////////////////////
  // transfer sequencing
  ////////////////////////////////////////

  lsu_ctrl_fsm u_ctrl_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .split_i       (split),
    .we_i          (lsu_req_i.we),
    .mem_addr_i    (data_o.addr),
    .req_addr_i    (lsu_req_i.addr),
    .data_gnt_i    (data_gnt_i),
    .data_rsp_i    (data_i),
    .data_req_o    (data_req_o),
    .grant_o       (grant),
    .second_part_o (second_part),
    .valid_o       (valid_o),
    .load_err_o    (load_err_o),
    .store_err_o   (store_err_o),
    .busy_o        (busy_o),
    .addr_last_o   (addr_last_o)
  );

  ////////////////////////////////////////
  // load data alignment
  ////////////////////////////////////////

  lsu_rdata_align u_rdata_align (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .grant_i       (grant),
    .second_part_i (second_part),
    .lsu_req_i     (lsu_req_i),
    .data_rsp_i    (data_i),
    .rdata_o       (rdata_o)
  );

endmodule

// File: sim/lsu_asserts.sv
// bus-protocol assertions of the load-store unit, bound to lsu_top by the testbench
module lsu_asserts (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              valid_o,
  input logic              load_err_o,
  input logic              store_err_o,
  input logic              busy_o,
  input logic              data_req_o,
  input lsu_pkg::mem_req_t data_o,
  input logic              data_gnt_i,
  input lsu_pkg::mem_rsp_t data_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // granted transfer whose rvalid has not come back yet
  logic awaiting_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      awaiting_q <= 1'b0;
    end else if (data_req_o && data_gnt_i) begin
      awaiting_q <= 1'b1;
    end else if (data_i.rvalid) begin
      awaiting_q <= 1'b0;
    end
  end

  // one outstanding transfer, a new grant needs the old rvalid
  one_outstanding: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (data_req_o && data_gnt_i) |-> (!awaiting_q || data_i.rvalid))
    else $error("grant seen while a response is still awaited");

  no_rvalid_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_i.rvalid |-> busy_o)
    else $error("rvalid seen while the unit is idle");

  // error flags only with an erroring rvalid that also ends the access
  err_with_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (load_err_o || store_err_o) |-> (data_i.rvalid && data_i.err && valid_o))
    else $error("error flag raised without an erroring rvalid and valid");

  // word aligned and known
  addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> (!$isunknown(data_o.addr) && (data_o.addr[1:0] == 2'b00)))
    else $error("bus address unaligned or unknown during a request");

endmodule

// File: sim/tb_lsu_top.sv
// random-stimulus testbench of the load-store unit, with byte memory, bus responder and model
module tb_lsu_top;

  timeunit 1ns;
  timeprecision 100ps;

  import lsu_pkg::*;

  localparam int unsigned NumTests  = 400;
  // every access fits in 16 cycles with the delays drawn below
  localparam int unsigned MaxCycles = 10 + NumTests * 16;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      req;
  lsu_req_t  lsu_req;
  logic      valid, load_err, store_err, busy, data_req, data_gnt;
  lsu_word_t rdata;
  lsu_addr_t addr_last;
  mem_req_t  bus_req;
  mem_rsp_t  bus_rsp;

  // bus memory and the model's own copy
  logic [7:0]  mem [64];
  logic [7:0]  exp_mem [64];
  logic [31:0] lfsr_q = 32'h86c3ab13;
  int unsigned errors = 0;
  int unsigned passed = 0;
  int unsigned failed = 0;
  int unsigned cycles = 0;

  // responder state
  int unsigned gnt_cnt, rsp_cnt;
  logic        rsp_pending, rsp_err, held;
  lsu_word_t   rsp_word;
  mem_req_t    held_req;

  lsu_top DUT (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_i       (req),
    .lsu_req_i   (lsu_req),
    .valid_o     (valid),
    .rdata_o     (rdata),
    .load_err_o  (load_err),
    .store_err_o (store_err),
    .busy_o      (busy),
    .addr_last_o (addr_last),
    .data_req_o  (data_req),
    .data_o      (bus_req),
    .data_gnt_i  (data_gnt),
    .data_i      (bus_rsp)
  );

  bind lsu_top lsu_asserts u_lsu_asserts (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid_o     (valid_o),
    .load_err_o  (load_err_o),
    .store_err_o (store_err_o),
    .busy_o      (busy_o),
    .data_req_o  (data_req_o),
    .data_o      (data_o),
    .data_gnt_i  (data_gnt_i),
    .data_i      (data_i)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("timeout after %0d cycles, the run did not finish", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // galois lfsr, one step per bit
  function automatic logic [31:0] take_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned k = 0; k < n; k++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  function automatic int unsigned size_of(input lsu_type_e dtype);
    return (dtype == LSU_WORD) ? 4 : (dtype == LSU_HALF) ? 2 : 1;
  endfunction

  // lanes of bytes addr..addr+size-1 that fall into the given part
  function automatic lsu_be_t lanes_of(input logic [1:0] off, input int unsigned size,
                                       input int unsigned part);
    lsu_be_t be;
    be = '0;
    for (int unsigned j = 0; j < size; j++) begin
      if ((off + j >= 4) == (part == 1)) begin
        be[(off + j) % 4] = 1'b1;
      end
    end
    return be;
  endfunction

  // expected load value straight from the model's bytes
  function automatic lsu_word_t load_value(input lsu_req_t r);
    lsu_word_t   v;
    int unsigned n;
    n = size_of(r.dtype);
    v = '0;
    for (int unsigned j = 0; j < n; j++) begin
      v[8*j +: 8] = exp_mem[(r.addr + j) % 64];
    end
    if (r.sign_ext && n == 1) v = {{24{v[7]}}, v[7:0]};
    if (r.sign_ext && n == 2) v = {{16{v[15]}}, v[15:0]};
    return v;
  endfunction

  // bytes of an errored part and everything after it are lost
  task automatic apply_store(input lsu_req_t r, input logic [1:0] errs);
    int unsigned part;
    for (int unsigned j = 0; j < size_of(r.dtype); j++) begin
      part = (r.addr[1:0] + j >= 4) ? 1 : 0;
      if (!errs[0] && !(part == 1 && errs[1])) begin
        exp_mem[(r.addr + j) % 64] = r.wdata[8*j +: 8];
      end
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR %0t %s", $time, msg);
    errors++;
  endtask

  task automatic check_word(input string name, input lsu_word_t got, input lsu_word_t exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input lsu_addr_t got, input lsu_addr_t exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_be(input string name, input lsu_be_t got, input lsu_be_t exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // flags as {load_err, store_err}
  task automatic check_err(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // answer a granted transfer, writes skipped when an error is injected
  task automatic serve(input mem_req_t m);
    int unsigned base;
    base        = m.addr % 64;
    rsp_err     = (take_bits(4) == 0);
    rsp_cnt     = take_bits(2) % 3;
    rsp_pending = 1'b1;
    for (int unsigned l = 0; l < 4; l++) begin
      rsp_word[8*l +: 8] = mem[base + l];
      if (m.we && m.be[l] && !rsp_err) begin
        mem[base + l] = m.wdata[8*l +: 8];
      end
    end
  endtask

  ////////////////////////////////////////
  // one access, entered and left at a falling edge
  ////////////////////////////////////////

  task automatic run_access(input int unsigned idx, input lsu_req_t r);
    logic [1:0]  errs;
    logic        done;
    logic        split;
    logic        last_err;
    int unsigned parts;
    int unsigned errs_before;
    lsu_addr_t   word_addr;
    errs_before = errors;
    errs        = '0;
    done        = 1'b0;
    parts       = 0;
    split       = (r.addr[1:0] + size_of(r.dtype)) > 4;
    word_addr   = {r.addr[31:2], 2'b00};
    req         = 1'b1;
    lsu_req     = r;
    while (!done) begin
      data_gnt       = (gnt_cnt == 0);
      bus_rsp.rvalid = rsp_pending && (rsp_cnt == 0);
      bus_rsp.err    = bus_rsp.rvalid && rsp_err;
      bus_rsp.rdata  = rsp_word;
      @(posedge clk);
      // core request still held, so the unit has work pending
      check_flag("busy_o", busy, 1'b1);
      if (held && (!data_req || bus_req !== held_req)) begin
        report_error("bus request changed before it was granted");
      end
      held = 1'b0;
      if (bus_rsp.rvalid) rsp_pending = 1'b0;
      else if (rsp_pending) rsp_cnt--;
      if (data_req && data_gnt) begin
        if (parts >= (split ? 2 : 1)) begin
          report_error("unexpected extra bus transfer");
        end else begin
          check_addr("data_o.addr", bus_req.addr, word_addr + 32'(4 * parts));
          check_be("data_o.be", bus_req.be, lanes_of(r.addr[1:0], size_of(r.dtype), parts));
          serve(bus_req);
          errs[parts] = rsp_err;
        end
        parts++;
        gnt_cnt = take_bits(2);
      end else if (data_req) begin
        held     = 1'b1;
        held_req = bus_req;
        gnt_cnt--;
      end
      if (valid) begin
        done = 1'b1;
        if (parts != ((split && !errs[0]) ? 2 : 1)) begin
          report_error("wrong number of bus transfers for the access");
        end
        check_addr("addr_last_o", addr_last, (parts == 2) ? word_addr + 32'd4 : r.addr);
        last_err = (parts == 2) ? errs[1] : errs[0];
        check_err("load_err_o,store_err_o", {load_err, store_err},
                  {last_err & ~r.we, last_err & r.we});
        if (!r.we && !last_err) check_word("rdata_o", rdata, load_value(r));
        if (r.we) apply_store(r, errs);
      end
      @(negedge clk);
    end
    if (errors == errs_before) passed++;
    else failed++;
    $display("test %0d %s size %0d addr %h transfers %0d %s", idx, r.we ? "store" : "load",
             size_of(r.dtype), r.addr, parts, (errors == errs_before) ? "ok" : "failed");
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    lsu_req_t   r;
    lsu_addr_t  prev_addr;
    logic [1:0] sel;
    req         = 1'b0;
    lsu_req     = '0;
    data_gnt    = 1'b0;
    bus_rsp     = '0;
    rst_n       = 1'b0;
    gnt_cnt     = 0;
    rsp_cnt     = 0;
    rsp_pending = 1'b0;
    rsp_err     = 1'b0;
    rsp_word    = '0;
    held        = 1'b0;
    held_req    = '0;
    prev_addr   = '0;
    for (int i = 0; i < 64; i++) begin
      mem[i]     = 8'(i * 37 + 11);
      exp_mem[i] = mem[i];
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int unsigned i = 0; i < NumTests; i++) begin
      r.we       = 1'(take_bits(1));
      sel        = 2'(take_bits(2));
      r.dtype    = (sel == 2'd1) ? LSU_HALF : (sel == 2'd2) ? LSU_BYTE : LSU_WORD;
      r.sign_ext = 1'(take_bits(1));
      r.addr     = take_bits(6);
      r.wdata    = take_bits(32);
      // every second access reads back where the previous one went
      if (i % 2 == 1) begin
        r.we   = 1'b0;
        r.addr = prev_addr;
      end
      prev_addr = r.addr;
      if (take_bits(1) != 0) begin
        req            = 1'b0;
        bus_rsp.rvalid = 1'b0;
        bus_rsp.err    = 1'b0;
        @(posedge clk);
        if (valid || data_req) report_error("bus request or valid without a core request");
        check_flag("busy_o", busy, 1'b0);
        @(negedge clk);
      end
      run_access(i, r);
    end
    req = 1'b0;
    $display("tests %0d passed %0d failed %0d check errors %0d", NumTests, passed, failed,
             errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: lsu_top.f
src/lsu_pkg.sv
src/lsu_req_decode.sv
src/lsu_ctrl_fsm.sv
src/lsu_rdata_align.sv
src/lsu_top.sv
sim/lsu_asserts.sv
sim/tb_lsu_top.sv
